//--- common/rv_wb_cfg.svh
`ifndef RV_WB_CFG_SVH
`define RV_WB_CFG_SVH

// Register and data path width
// The multiply product is twice this width
`define RV_XLEN 32

// Width of the trap cause code carried with each instruction
`define RV_TRAP_W 2

`endif

//--- common/rv_isa_pkg.sv
`default_nettype none

`include "rv_wb_cfg.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0]   xlen_t;
  typedef logic [31:0]           instr_t;
  typedef logic [2*`RV_XLEN-1:0] prod_t;
  typedef logic [`RV_TRAP_W-1:0] trap_code_t;
  typedef logic [6:0]            opcode_t;

  // Major opcodes that can write rd
  localparam opcode_t OP     = 7'b0110011;
  localparam opcode_t OP_IMM = 7'b0010011;
  localparam opcode_t LUI    = 7'b0110111;
  localparam opcode_t AUIPC  = 7'b0010111;
  localparam opcode_t LOAD   = 7'b0000011;
  localparam opcode_t JAL    = 7'b1101111;
  localparam opcode_t JALR   = 7'b1100111;
  localparam opcode_t SYSTEM = 7'b1110011;

  // funct7 that marks the M extension inside OP
  localparam logic [6:0] FUNCT7_MEXT = 7'b0000001;

  // Multiply group, funct3 bit 2 clear
  localparam logic [2:0] F3_MUL    = 3'b000;
  localparam logic [2:0] F3_MULH   = 3'b001;
  localparam logic [2:0] F3_MULHSU = 3'b010;
  localparam logic [2:0] F3_MULHU  = 3'b011;

  localparam instr_t EBREAK_INSTR = 32'h0010_0073;

  // Source of the value written to rd
  typedef enum logic [2:0] {
    RES_ALU  = 3'd0,
    RES_LOAD = 3'd1,
    RES_PC4  = 3'd2,
    RES_JB   = 3'd3,
    RES_CSR  = 3'd4,
    RES_MEXT = 3'd5
  } res_src_e;

endpackage

`default_nettype wire

//--- common/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

  // Bundle handed over by the memory stage
  typedef struct packed {
    rv_isa_pkg::instr_t     instr;
    rv_isa_pkg::xlen_t      pc_plus4;
    rv_isa_pkg::xlen_t      alu_result;
    rv_isa_pkg::xlen_t      ld_data;
    rv_isa_pkg::xlen_t      jb_tgt;
    rv_isa_pkg::xlen_t      csr_rdata;
    // Division finishes before write-back
    rv_isa_pkg::xlen_t      div_result;
    rv_isa_pkg::xlen_t      rs1_data;
    rv_isa_pkg::xlen_t      rs2_data;
    // Unsigned product, sign fixed up here
    rv_isa_pkg::prod_t      product;
    logic                   trap;
    rv_isa_pkg::trap_code_t trap_code;
  } wb_in_t;

  // Record presented on the retirement port
  typedef struct packed {
    rv_isa_pkg::instr_t     instr;
    rv_isa_pkg::xlen_t      pc;
    rv_isa_pkg::xlen_t      rs1_data;
    rv_isa_pkg::xlen_t      rs2_data;
    rv_isa_pkg::xlen_t      rd_data;
    logic                   trap;
    rv_isa_pkg::trap_code_t trap_code;
    logic                   reg_write;
    logic                   ebreak;
  } retire_t;

endpackage

`default_nettype wire

//--- verilog/wb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module wb_decode (
  input  rv_isa_pkg::instr_t   instr_i,
  output rv_isa_pkg::res_src_e res_src_o,
  output logic                 reg_write_o,
  output logic                 ebreak_o
);
  import rv_isa_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rd;
  logic       writes_rd;

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    res_src_o = RES_ALU;
    writes_rd = 1'b0;
    case (opcode)
      OP: begin
        writes_rd = 1'b1;
        if (funct7 == FUNCT7_MEXT) begin
          res_src_o = RES_MEXT;
        end
      end
      OP_IMM, LUI: begin
        writes_rd = 1'b1;
      end
      LOAD: begin
        res_src_o = RES_LOAD;
        writes_rd = 1'b1;
      end
      // Link value is the return address
      JAL, JALR: begin
        res_src_o = RES_PC4;
        writes_rd = 1'b1;
      end
      // pc + imm comes from the branch target adder
      AUIPC: begin
        res_src_o = RES_JB;
        writes_rd = 1'b1;
      end
      SYSTEM: begin
        // funct3 zero is ECALL, EBREAK or MRET, none of which write rd
        if (funct3 != 3'b000) begin
          res_src_o = RES_CSR;
          writes_rd = 1'b1;
        end
      end
      default: begin
        writes_rd = 1'b0;
      end
    endcase
  end

  // Writes to x0 are dropped
  assign reg_write_o = writes_rd && (rd != 5'd0);

  assign ebreak_o = (instr_i == EBREAK_INSTR);

endmodule

`default_nettype wire

//--- verilog/mul_sign_fix.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_wb_cfg.svh"

module mul_sign_fix (
  input  rv_isa_pkg::prod_t product_i,
  input  rv_isa_pkg::xlen_t rs1_data_i,
  input  rv_isa_pkg::xlen_t rs2_data_i,
  input  logic [2:0]        funct3_i,
  output rv_isa_pkg::xlen_t mul_result_o
);
  import rv_isa_pkg::*;

  xlen_t prod_lo;
  xlen_t prod_hi;
  xlen_t corr_rs1;
  xlen_t corr_rs2;
  logic  rs1_neg;
  logic  rs2_neg;

  assign prod_lo = product_i[`RV_XLEN-1:0];
  assign prod_hi = product_i[2*`RV_XLEN-1:`RV_XLEN];

  assign rs1_neg = rs1_data_i[`RV_XLEN-1];
  assign rs2_neg = rs2_data_i[`RV_XLEN-1];

  // A negative signed operand read as unsigned is too large by 2^XLEN,
  // so the high half carries one extra copy of the other operand
  assign corr_rs1 = rs1_neg ? rs2_data_i : '0;
  assign corr_rs2 = rs2_neg ? rs1_data_i : '0;

  always_comb begin
    case (funct3_i)
      F3_MUL: begin
        mul_result_o = prod_lo;
      end
      F3_MULH: begin
        mul_result_o = prod_hi - corr_rs1 - corr_rs2;
      end
      // rs1 signed, rs2 unsigned
      F3_MULHSU: begin
        mul_result_o = prod_hi - corr_rs1;
      end
      F3_MULHU: begin
        mul_result_o = prod_hi;
      end
      // Division codes, the result is not selected downstream
      default: begin
        mul_result_o = prod_lo;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/result_select.sv
`timescale 1ns/1ps
`default_nettype none

module result_select (
  input  rv_pipe_pkg::wb_in_t  bundle_i,
  input  rv_isa_pkg::res_src_e res_src_i,
  input  rv_isa_pkg::xlen_t    mul_result_i,
  output rv_isa_pkg::xlen_t    rd_data_o
);
  import rv_isa_pkg::*;

  xlen_t mext_result;

  // funct3 bit 2 set means DIV/DIVU/REM/REMU
  assign mext_result = bundle_i.instr[14] ? bundle_i.div_result : mul_result_i;

  always_comb begin
    case (res_src_i)
      RES_ALU: begin
        rd_data_o = bundle_i.alu_result;
      end
      RES_LOAD: begin
        rd_data_o = bundle_i.ld_data;
      end
      RES_PC4: begin
        rd_data_o = bundle_i.pc_plus4;
      end
      RES_JB: begin
        rd_data_o = bundle_i.jb_tgt;
      end
      RES_CSR: begin
        rd_data_o = bundle_i.csr_rdata;
      end
      RES_MEXT: begin
        rd_data_o = mext_result;
      end
      default: begin
        rd_data_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/retire_reg.sv
`timescale 1ns/1ps
`default_nettype none

module retire_reg (
  input  logic                clk,
  input  logic                arst_n_i,
  input  rv_pipe_pkg::wb_in_t bundle_i,
  input  rv_isa_pkg::xlen_t   rd_data_i,
  input  logic                reg_write_i,
  input  logic                ebreak_i,
  input  logic                s_valid_i,
  output logic                s_ready_o,
  output logic                m_valid_o,
  input  logic                m_ready_i,
  output rv_pipe_pkg::retire_t retire_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  retire_t rec_d;
  retire_t rec_q;
  logic    valid_q;

  // Free when empty or when the held record leaves this cycle
  assign s_ready_o = !valid_q || m_ready_i;

  always_comb begin
    rec_d.instr     = bundle_i.instr;
    rec_d.pc        = bundle_i.pc_plus4 - xlen_t'(4);
    rec_d.rs1_data  = bundle_i.rs1_data;
    rec_d.rs2_data  = bundle_i.rs2_data;
    rec_d.rd_data   = rd_data_i;
    rec_d.trap      = bundle_i.trap;
    rec_d.trap_code = bundle_i.trap_code;
    rec_d.reg_write = reg_write_i;
    rec_d.ebreak    = ebreak_i;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (s_ready_o) begin
      valid_q <= s_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (s_ready_o && s_valid_i) begin
      rec_q <= rec_d;
    end
  end

  assign m_valid_o = valid_q;
  assign retire_o  = rec_q;

endmodule

`default_nettype wire

//--- verilog/rv_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rv_wb_stage (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  rv_pipe_pkg::wb_in_t  wb_bundle_i,
  input  logic                 s_valid_i,
  output logic                 s_ready_o,
  output logic                 m_valid_o,
  input  logic                 m_ready_i,
  output rv_pipe_pkg::retire_t retire_o,
  // Same-cycle value for the register file write port
  output rv_isa_pkg::xlen_t    rd_data_wb_o
);
  import rv_isa_pkg::*;

  res_src_e res_src;
  logic     reg_write;
  logic     ebreak;
  xlen_t    mul_result;

  wb_decode i_wb_decode (
    .instr_i     (wb_bundle_i.instr),
    .res_src_o   (res_src),
    .reg_write_o (reg_write),
    .ebreak_o    (ebreak)
  );

  mul_sign_fix i_mul_sign_fix (
    .product_i    (wb_bundle_i.product),
    .rs1_data_i   (wb_bundle_i.rs1_data),
    .rs2_data_i   (wb_bundle_i.rs2_data),
    .funct3_i     (wb_bundle_i.instr[14:12]),
    .mul_result_o (mul_result)
  );

  result_select i_result_select (
    .bundle_i     (wb_bundle_i),
    .res_src_i    (res_src),
    .mul_result_i (mul_result),
    .rd_data_o    (rd_data_wb_o)
  );

  retire_reg i_retire_reg (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .bundle_i    (wb_bundle_i),
    .rd_data_i   (rd_data_wb_o),
    .reg_write_i (reg_write),
    .ebreak_i    (ebreak),
    .s_valid_i   (s_valid_i),
    .s_ready_o   (s_ready_o),
    .m_valid_o   (m_valid_o),
    .m_ready_i   (m_ready_i),
    .retire_o    (retire_o)
  );

endmodule

`default_nettype wire

//--- verification/tb_rv_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_wb_stage;
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int VEC_WORDS  = 14;
  localparam int MAX_VEC    = 64;

  logic    clk = 1'b0;
  logic    arst_n_i;
  logic    s_valid_i;
  logic    s_ready_o;
  logic    m_valid_o;
  logic    m_ready_i;
  wb_in_t  wb_bundle_i;
  retire_t retire_o;
  xlen_t   rd_data_wb_o;

  // Each vector takes 14 words, in the column order of the vector file
  logic [31:0] vec_mem [0:MAX_VEC*VEC_WORDS-1];
  int          vec_err [0:MAX_VEC-1];
  retire_t     exp_q[$];
  int          idx_q[$];
  retire_t     exp_rec;
  retire_t     held_rec;
  int          exp_idx;
  int          seed = 32'h4f3a76ba;
  int          n_vec = 0;
  int          next_vec = 0;
  int          retired = 0;
  int          stalls = 0;
  int          err_cnt = 0;
  int          failed_tests = 0;
  int          rst_err = 0;
  int          bp_err = 0;
  int          ord_err = 0;
  bit          pending = 1'b0;
  bit          prev_acc = 1'b0;
  bit          prev_stall = 1'b0;

  rv_wb_stage i_rv_wb_stage (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .wb_bundle_i  (wb_bundle_i),
    .s_valid_i    (s_valid_i),
    .s_ready_o    (s_ready_o),
    .m_valid_o    (m_valid_o),
    .m_ready_i    (m_ready_i),
    .retire_o     (retire_o),
    .rd_data_wb_o (rd_data_wb_o)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // Columns 0 to 10 are the bundle fields and column 11 is {trap, trap_code}
  function automatic wb_in_t bundle_from_vector(input int v);
    int b;
    b = v * VEC_WORDS;
    return {vec_mem[b], vec_mem[b+1], vec_mem[b+2], vec_mem[b+3], vec_mem[b+4],
            vec_mem[b+5], vec_mem[b+6], vec_mem[b+7], vec_mem[b+8], vec_mem[b+9],
            vec_mem[b+10], vec_mem[b+11][2:0]};
  endfunction

  // Retired pc is the instruction address, one word below pc_plus4
  function automatic retire_t expected_record(input int v);
    int b;
    b = v * VEC_WORDS;
    return {vec_mem[b], vec_mem[b+1] - 32'd4, vec_mem[b+7], vec_mem[b+8],
            vec_mem[b+12], vec_mem[b+11][2:0], vec_mem[b+13][1:0]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val, inout int errs);
    assert (act_val === exp_val) else begin
      $display("ERR %s exp=%h act=%h", name, exp_val, act_val);
      errs++;
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errs);
      failed_tests++;
    end
  endtask

  initial begin : main_seq
    arst_n_i    = 1'b0;
    s_valid_i   = 1'b0;
    m_ready_i   = 1'b0;
    wb_bundle_i = '0;
    $readmemh("verification/rv_wb_vectors.txt", vec_mem);
    while (n_vec < MAX_VEC && !$isunknown(vec_mem[n_vec*VEC_WORDS])) begin
      n_vec++;
    end
    assert (n_vec > 0) else begin
      $display("no vectors could be read from verification/rv_wb_vectors.txt");
      err_cnt++;
    end
    repeat (10) @(negedge clk);
    arst_n_i = 1'b1;
    #(CLK_PERIOD/4);
    check_value("reset m_valid_o", 32'd0, m_valid_o, rst_err);
    check_value("reset s_ready_o", 32'd1, s_ready_o, rst_err);
    report_test("reset", rst_err);
    while (retired < n_vec) begin
      @(negedge clk);
      // A presented bundle stays put until it is taken
      if (!pending && next_vec < n_vec && ($random(seed) & 3) != 0) begin
        wb_bundle_i = bundle_from_vector(next_vec);
        pending     = 1'b1;
      end
      s_valid_i = pending;
      m_ready_i = ($random(seed) & 3) != 0;
      // Sample midway between the falling and the rising edge
      #(CLK_PERIOD/4);
      if (s_valid_i) begin
        check_value($sformatf("vec%02d rd_data_wb_o", next_vec),
                    vec_mem[next_vec*VEC_WORDS+12], rd_data_wb_o, vec_err[next_vec]);
      end
      if (prev_acc) begin
        check_value("latency m_valid_o", 32'd1, m_valid_o, bp_err);
      end
      if (prev_stall) begin
        assert (retire_o === held_rec) else begin
          $display("ERR backpressure retire_o exp=%h act=%h", held_rec, retire_o);
          bp_err++;
          err_cnt++;
        end
      end
      if (m_valid_o && !m_ready_i) begin
        stalls++;
        check_value("backpressure s_ready_o", 32'd0, s_ready_o, bp_err);
      end
      // Held record leaves before the new bundle is queued
      if (m_valid_o && m_ready_i) begin
        assert (exp_q.size() > 0) else begin
          $display("a record retired although no input was outstanding");
          ord_err++;
          err_cnt++;
        end
        if (exp_q.size() > 0) begin
          exp_rec = exp_q.pop_front();
          exp_idx = idx_q.pop_front();
          assert (retire_o === exp_rec) else begin
            $display("ERR vec%02d retire_o exp=%h act=%h", exp_idx, exp_rec, retire_o);
            vec_err[exp_idx]++;
            err_cnt++;
          end
          report_test($sformatf("vec%02d", exp_idx), vec_err[exp_idx]);
          retired++;
        end
      end
      prev_acc = s_valid_i && s_ready_o;
      if (prev_acc) begin
        exp_q.push_back(expected_record(next_vec));
        idx_q.push_back(next_vec);
        next_vec++;
        pending = 1'b0;
      end
      prev_stall = m_valid_o && !m_ready_i;
      held_rec   = retire_o;
    end
    @(negedge clk);
    m_ready_i = 1'b1;
    #(CLK_PERIOD/4);
    check_value("order m_valid_o after drain", 32'd0, m_valid_o, ord_err);
    report_test("order", ord_err);
    assert (stalls > 0) else begin
      $display("no back-pressure cycle occurred, so the stall path was never exercised");
      bp_err++;
      err_cnt++;
    end
    report_test("backpressure", bp_err);
    $display("summary: %0d tests, %0d failed, %0d check errors",
             n_vec + 3, failed_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // About eight cycles per vector plus margin, counted once the vectors are loaded
  initial begin : watchdog
    @(posedge arst_n_i);
    #((n_vec * 8 + 20) * CLK_PERIOD);
    $display("timeout: the run did not finish within the expected number of cycles");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/rv_wb_vectors.txt
// Bundle: instr pc_plus4 alu_result ld_data jb_tgt csr_rdata div_result rs1 rs2 prod_hi prod_lo
// then {trap,trap_code}, then the expected rd value and {reg_write,ebreak}
003100b3 1004 00000579 1d1d b0b0 c0c0 d0d0 123 456 0 0 0 00000579 2
12345337 1008 12345000 1d1d b0b0 c0c0 d0d0 0 0 0 0 0 12345000 2
00012383 100c a0a0 deadbeef b0b0 c0c0 d0d0 2000 0 0 0 0 deadbeef 2
00012383 1010 a0a0 0badf00d b0b0 c0c0 d0d0 2004 0 0 0 5 0badf00d 2
008000ef 1014 a0a0 1d1d 00001018 c0c0 d0d0 0 0 0 0 0 00001014 2
00008067 1018 a0a0 1d1d 00001014 c0c0 d0d0 1014 0 0 0 0 00001018 0
00001517 101c a0a0 1d1d 00002018 c0c0 d0d0 0 0 0 0 0 00002018 2
b00025f3 1020 a0a0 1d1d b0b0 00abcdef d0d0 0 0 0 0 0 00abcdef 2
00100073 1024 a0a0 1d1d b0b0 c0c0 d0d0 0 0 0 0 0 0000a0a0 1
00000073 1028 a0a0 1d1d b0b0 c0c0 d0d0 0 0 0 0 7 0000a0a0 0
02e6c633 102c a0a0 1d1d b0b0 c0c0 fffffffd 7 fffffffe 0 e 0 fffffffd 2
02e6f633 1030 a0a0 1d1d b0b0 c0c0 00000001 7 2 0 e 0 00000001 2
02e687b3 1034 a0a0 1d1d b0b0 c0c0 d0d0 fffffffe 3 2 fffffffa 0 fffffffa 2
02e697b3 1038 a0a0 1d1d b0b0 c0c0 d0d0 fffffffe 3 2 fffffffa 0 ffffffff 2
02e6a7b3 103c a0a0 1d1d b0b0 c0c0 d0d0 fffffffe 3 2 fffffffa 0 ffffffff 2
02e6b7b3 1040 a0a0 1d1d b0b0 c0c0 d0d0 fffffffe 3 2 fffffffa 0 00000002 2
02e69033 1044 a0a0 1d1d b0b0 c0c0 d0d0 fffffffe fffffffd fffffffb 6 0 00000000 0
02e6a7b3 1048 a0a0 1d1d b0b0 c0c0 d0d0 ffffffff 80000000 7fffffff 80000000 0 ffffffff 2
02e6a7b3 104c a0a0 1d1d b0b0 c0c0 d0d0 5 ffffffff 4 fffffffb 0 00000004 2
02e6b7b3 1050 a0a0 1d1d b0b0 c0c0 d0d0 ffffffff ffffffff fffffffe 1 0 fffffffe 2

//--- sources.f
+incdir+common
common/rv_isa_pkg.sv
common/rv_pipe_pkg.sv
verilog/wb_decode.sv
verilog/mul_sign_fix.sv
verilog/result_select.sv
verilog/retire_reg.sv
verilog/rv_wb_stage.sv
verification/tb_rv_wb_stage.sv
